// File: clock_display.f
+incdir+verilog
verilog/clock_display_pkg.sv
verilog/bcd_field_incr.sv
verilog/time_editor.sv
verilog/digit_framer.sv
verilog/clock_display.sv
tests/clock_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the clock_display testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f clock_display.f \
  --top-module clock_display_tb -o clock_display_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/clock_display_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" "$log_file"; then
  exit 1
fi
exit 0

// File: tests/clock_display_tb.sv
`include "clock_display_defines.svh"

module clock_display_tb;

  logic                         clk;
  logic                         rst_n;
  clock_display_pkg::mode_e     mode;
  clock_display_pkg::bcd_time_t live_time;
  logic                         btn_down;
  logic                         set_counter;
  clock_display_pkg::bcd_time_t set_time;
  clock_display_pkg::led_bank_t leds;

  clock_display_pkg::bcd_time_t exp_edit;
  clock_display_pkg::bcd_time_t exp_set_time;
  clock_display_pkg::mode_e     exp_prev_mode;
  logic                         exp_set_counter;
  clock_display_pkg::led_bank_t exp_leds;

  int          errors = 0;
  int          cycles = 0;
  int unsigned lcg_state = 14771;

  clock_display u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .live_time   (live_time),
    .btn_down    (btn_down),
    .set_counter (set_counter),
    .set_time    (set_time),
    .leds        (leds)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycles++;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;  // low bits cycle too fast
  endfunction

  function automatic logic [15:0] to_bcd(int unsigned v);
    return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
  endfunction

  function automatic int unsigned from_bcd(logic [15:0] b);
    return int'(b[15:12]) * 1000 + int'(b[11:8]) * 100 + int'(b[7:4]) * 10 + int'(b[3:0]);
  endfunction

  // one press wraps to zero at or above the field maximum
  function automatic logic [15:0] bcd_step(logic [15:0] v, logic [15:0] max);
    int unsigned n;
    n = from_bcd(v);
    if (n >= from_bcd(max)) return '0;
    return to_bcd(n + 1);
  endfunction

  function automatic clock_display_pkg::bcd_time_t rand_time();
    clock_display_pkg::bcd_time_t t;
    t.year   = to_bcd(lcg_next() % 10000);
    t.month  = 8'(to_bcd(lcg_next() % 12 + 1));
    t.day    = 8'(to_bcd(lcg_next() % 31 + 1));
    t.hour   = 8'(to_bcd(lcg_next() % 24));
    t.minute = 8'(to_bcd(lcg_next() % 60));
    t.second = 8'(to_bcd(lcg_next() % 60));
    return t;
  endfunction

  function automatic bit is_edit(clock_display_pkg::mode_e m);
    case (m)
      clock_display_pkg::edit_second, clock_display_pkg::edit_minute,
      clock_display_pkg::edit_hour, clock_display_pkg::edit_day,
      clock_display_pkg::edit_month, clock_display_pkg::edit_year: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic clock_display_pkg::bcd_time_t bump_field(
      clock_display_pkg::bcd_time_t t, clock_display_pkg::mode_e m);
    clock_display_pkg::bcd_time_t r;
    r = t;
    case (m)
      clock_display_pkg::edit_second:
        r.second = 8'(bcd_step({8'h00, t.second}, {8'h00, `CD_SEC_MAX}));
      clock_display_pkg::edit_minute:
        r.minute = 8'(bcd_step({8'h00, t.minute}, {8'h00, `CD_MIN_MAX}));
      clock_display_pkg::edit_hour:
        r.hour = 8'(bcd_step({8'h00, t.hour}, {8'h00, `CD_HOUR_MAX}));
      clock_display_pkg::edit_day:
        r.day = 8'(bcd_step({8'h00, t.day}, {8'h00, `CD_DAY_MAX}));
      clock_display_pkg::edit_month:
        r.month = 8'(bcd_step({8'h00, t.month}, {8'h00, `CD_MONTH_MAX}));
      clock_display_pkg::edit_year:
        r.year = bcd_step(t.year, `CD_YEAR_MAX);
      default: ;
    endcase
    return r;
  endfunction

  function automatic clock_display_pkg::led_bank_t expected_bank(
      clock_display_pkg::bcd_time_t t, clock_display_pkg::mode_e m);
    logic [7:0][3:0]              codes;
    logic [7:0]                   dots;
    logic [7:0]                   blink;
    clock_display_pkg::led_bank_t bank;
    blink = 8'b00000000;
    if (m == clock_display_pkg::date_disp || m == clock_display_pkg::edit_day ||
        m == clock_display_pkg::edit_month || m == clock_display_pkg::edit_year) begin
      codes = {t.year, t.month, t.day};
      dots  = `CD_DOT_DATE;
    end else begin
      codes = {t.hour, `CD_SEP_CODE, t.minute, `CD_SEP_CODE, t.second};
      dots  = `CD_DOT_TIME;
    end
    case (m)
      clock_display_pkg::edit_second, clock_display_pkg::edit_day: blink = 8'b00000011;
      clock_display_pkg::edit_minute: blink = 8'b00011000;
      clock_display_pkg::edit_hour:   blink = 8'b11000000;
      clock_display_pkg::edit_month:  blink = 8'b00001100;
      clock_display_pkg::edit_year:   blink = 8'b11110000;
      default: ;
    endcase
    for (int i = 0; i < `CD_DIGITS; i++) begin
      bank[i].blink = blink[i];
      bank[i].dot   = dots[i];
      bank[i].code  = codes[i];
    end
    return bank;
  endfunction

  // reference model of the registered outputs
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_edit        <= '0;
      exp_set_time    <= '0;
      exp_prev_mode   <= clock_display_pkg::time_disp;
      exp_set_counter <= 1'b0;
      exp_leds        <= '0;
    end else begin
      exp_prev_mode   <= mode;
      exp_set_counter <= is_edit(exp_prev_mode) && (mode == clock_display_pkg::time_disp);
      if (is_edit(exp_prev_mode) && mode == clock_display_pkg::time_disp)
        exp_set_time <= exp_edit;
      if (mode == clock_display_pkg::time_disp || mode == clock_display_pkg::date_disp) begin
        exp_edit <= live_time;
        exp_leds <= expected_bank(live_time, mode);
      end else if (is_edit(mode)) begin
        if (!btn_down) exp_edit <= bump_field(exp_edit, mode);
        exp_leds <= expected_bank(exp_edit, mode);  // shows the copy before this edge
      end
    end
  end

  a_reset: assert property (@(posedge clk) !rst_n |-> (leds == '0 && !set_counter))
    else begin
      errors++;
      $display("Fail at %0t: in reset leds expected 0 actual %h, set_counter expected 0 actual %b",
               $time, $sampled(leds), $sampled(set_counter));
    end

  a_leds: assert property (@(posedge clk) leds == exp_leds)
    else begin
      errors++;
      $display("Fail at %0t: leds expected %h actual %h", $time, $sampled(exp_leds),
               $sampled(leds));
    end

  a_set_counter: assert property (@(posedge clk) set_counter == exp_set_counter)
    else begin
      errors++;
      $display("Fail at %0t: set_counter expected %b actual %b", $time,
               $sampled(exp_set_counter), $sampled(set_counter));
    end

  a_set_time: assert property (@(posedge clk) set_time == exp_set_time)
    else begin
      errors++;
      $display("Fail at %0t: set_time expected %h actual %h", $time, $sampled(exp_set_time),
               $sampled(set_time));
    end

  a_single_pulse: assert property (@(posedge clk) set_counter |-> !$past(set_counter))
    else begin
      errors++;
      $display("Fail at %0t: set_counter stayed high for more than one cycle", $time);
    end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic edit_field(clock_display_pkg::mode_e m, clock_display_pkg::bcd_time_t start,
                            int presses, clock_display_pkg::mode_e exit_mode);
    bit seen;
    seen      = 1'b0;
    mode      = clock_display_pkg::time_disp;
    btn_down  = 1'b1;
    live_time = start;
    next_cycle();  // edit copy picks up the start value
    mode      = m;
    btn_down  = 1'b0;
    live_time = rand_time();  // must not leak into the edit copy
    repeat (presses) next_cycle();
    btn_down = 1'b1;
    next_cycle();
    mode = exit_mode;
    if (exit_mode == clock_display_pkg::time_disp) begin
      for (int i = 0; i < 4 && !seen; i++) begin
        next_cycle();
        seen = set_counter;
      end
      if (!seen) begin
        errors++;
        $display("no commit pulse within 4 cycles after leaving edit mode %0d", m);
      end
    end
    repeat (2) next_cycle();
  endtask

  initial begin
    repeat (3000) @(posedge clk);
    $display("timeout: testbench did not reach its end within 3000 cycles");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    clock_display_pkg::bcd_time_t start;
    rst_n     = 1'b1;
    mode      = clock_display_pkg::time_disp;
    live_time = '0;
    btn_down  = 1'b1;
    #2 rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;

    for (int i = 0; i < 60; i++) begin
      mode      = (lcg_next() % 2 == 0) ? clock_display_pkg::time_disp :
                                          clock_display_pkg::date_disp;
      live_time = rand_time();
      next_cycle();
    end

    start = rand_time();
    start.second = 8'h57;
    edit_field(clock_display_pkg::edit_second, start, 5, clock_display_pkg::time_disp);
    start.minute = 8'h58;
    edit_field(clock_display_pkg::edit_minute, start, 4, clock_display_pkg::time_disp);
    start.hour = 8'h22;
    edit_field(clock_display_pkg::edit_hour, start, 3, clock_display_pkg::date_disp);
    mode = clock_display_pkg::time_disp;  // date to time gives no commit
    repeat (2) next_cycle();
    edit_field(clock_display_pkg::edit_hour, start, 3, clock_display_pkg::time_disp);
    start.day = 8'h30;
    edit_field(clock_display_pkg::edit_day, start, 3, clock_display_pkg::time_disp);
    start.month = 8'h11;
    edit_field(clock_display_pkg::edit_month, start, 3, clock_display_pkg::time_disp);
    start.year = 16'h1999;
    edit_field(clock_display_pkg::edit_year, start, 2, clock_display_pkg::time_disp);
    start.year = 16'h9999;
    edit_field(clock_display_pkg::edit_year, start, 2, clock_display_pkg::date_disp);

    mode     = clock_display_pkg::edit_minute;
    btn_down = 1'b0;
    next_cycle();
    for (int k = 8; k < 16; k++) begin
      mode = clock_display_pkg::mode_e'(4'(k));
      repeat (3) begin
        live_time = rand_time();
        next_cycle();
      end
    end
    btn_down = 1'b1;
    mode     = clock_display_pkg::edit_minute;  // exposes the held edit copy
    next_cycle();
    mode = clock_display_pkg::time_disp;
    repeat (4) next_cycle();

    $display("cycles checked: %0d, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/bcd_field_incr.sv
module bcd_field_incr #(
  parameter type field_t = logic [7:0],
  parameter field_t MAX = '1
) (
  input  field_t value,
  output field_t next_value
);

  localparam int WIDTH = $bits(field_t);
  localparam int NUM_DIGITS = WIDTH / 4;

  logic [WIDTH-1:0] value_bits;
  logic [WIDTH-1:0] sum;
  logic             at_max;

  assign value_bits = value;

  // ripple a decimal carry from the units digit upwards
  always_comb begin
    logic carry;
    carry = 1'b1;
    sum = value_bits;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      if (carry) begin
        if (value_bits[4*i +: 4] >= 4'd9) begin
          sum[4*i +: 4] = 4'd0;  // carry on to next digit
        end else begin
          sum[4*i +: 4] = value_bits[4*i +: 4] + 4'd1;
          carry = 1'b0;
        end
      end
    end
  end

  // BCD order matches binary order for valid codes
  assign at_max = (value >= MAX);

  assign next_value = at_max ? field_t'('0) : field_t'(sum);

endmodule

// File: verilog/clock_display.sv
module clock_display (
  input  logic                         clk,
  input  logic                         rst_n,
  input  clock_display_pkg::mode_e     mode,
  input  clock_display_pkg::bcd_time_t live_time,
  input  logic                         btn_down,   // active low
  output logic                         set_counter,
  output clock_display_pkg::bcd_time_t set_time,
  output clock_display_pkg::led_bank_t leds
);

  clock_display_pkg::bcd_time_t edit_time;

  time_editor u_time_editor (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .live_time   (live_time),
    .btn_down    (btn_down),
    .edit_time   (edit_time),
    .set_counter (set_counter),
    .set_time    (set_time)
  );

  digit_framer u_digit_framer (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .live_time (live_time),
    .edit_time (edit_time),
    .leds      (leds)
  );

endmodule

// File: verilog/clock_display_defines.svh
`ifndef CLOCK_DISPLAY_DEFINES_SVH
`define CLOCK_DISPLAY_DEFINES_SVH

// led positions on the display with index 7 leftmost
`define CD_DIGITS 8

// digit code that lights the dash between fields
`define CD_SEP_CODE 4'd10

// field maxima in BCD
`define CD_SEC_MAX 8'h59
`define CD_MIN_MAX 8'h59
`define CD_HOUR_MAX 8'h23
`define CD_DAY_MAX 8'h31
`define CD_MONTH_MAX 8'h12
`define CD_YEAR_MAX 16'h9999

// dot masks per layout
`define CD_DOT_TIME 8'b11111111
`define CD_DOT_DATE 8'b11101010

`endif

// File: verilog/clock_display_pkg.sv
`include "clock_display_defines.svh"

package clock_display_pkg;

  // codes 8 to 15 are left undecoded
  typedef enum logic [3:0] {
    time_disp   = 4'd0,
    date_disp   = 4'd1,
    edit_second = 4'd2,
    edit_minute = 4'd3,
    edit_hour   = 4'd4,
    edit_day    = 4'd5,
    edit_month  = 4'd6,
    edit_year   = 4'd7
  } mode_e;

  // all fields in BCD
  typedef struct packed {
    logic [15:0] year;
    logic [7:0]  month;
    logic [7:0]  day;
    logic [7:0]  hour;
    logic [7:0]  minute;
    logic [7:0]  second;
  } bcd_time_t;

  typedef struct packed {
    logic       blink;
    logic       dot;
    logic [3:0] code;  // 0-9 digit, 10 separator
  } led_digit_t;

  typedef led_digit_t [`CD_DIGITS-1:0] led_bank_t;

endpackage

// File: verilog/digit_framer.sv
`include "clock_display_defines.svh"

module digit_framer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  clock_display_pkg::mode_e     mode,
  input  clock_display_pkg::bcd_time_t live_time,
  input  clock_display_pkg::bcd_time_t edit_time,
  output clock_display_pkg::led_bank_t leds
);

  clock_display_pkg::bcd_time_t shown;
  clock_display_pkg::led_bank_t next_bank;

  logic [`CD_DIGITS-1:0][3:0] time_codes;
  logic [`CD_DIGITS-1:0][3:0] date_codes;
  logic [`CD_DIGITS-1:0]      blink_mask;
  logic                       is_date;
  logic                       decoded;
  logic                       live_mode;

  assign live_mode = (mode == clock_display_pkg::time_disp) ||
                     (mode == clock_display_pkg::date_disp);

  assign shown = live_mode ? live_time : edit_time;

  // hh-mm-ss
  assign time_codes = {shown.hour, `CD_SEP_CODE, shown.minute, `CD_SEP_CODE, shown.second};

  // yyyymmdd
  assign date_codes = {shown.year, shown.month, shown.day};

  always_comb begin
    decoded    = 1'b1;
    is_date    = 1'b0;
    blink_mask = '0;
    case (mode)
      clock_display_pkg::time_disp: ;
      clock_display_pkg::date_disp: begin
        is_date = 1'b1;
      end
      clock_display_pkg::edit_second: begin
        blink_mask = 8'b00000011;
      end
      clock_display_pkg::edit_minute: begin
        blink_mask = 8'b00011000;
      end
      clock_display_pkg::edit_hour: begin
        blink_mask = 8'b11000000;
      end
      clock_display_pkg::edit_day: begin
        is_date    = 1'b1;
        blink_mask = 8'b00000011;
      end
      clock_display_pkg::edit_month: begin
        is_date    = 1'b1;
        blink_mask = 8'b00001100;
      end
      clock_display_pkg::edit_year: begin
        is_date    = 1'b1;
        blink_mask = 8'b11110000;
      end
      default: begin
        decoded = 1'b0;  // codes 8-15 hold the display
      end
    endcase
  end

  always_comb begin
    logic [`CD_DIGITS-1:0] dot_mask;
    dot_mask = is_date ? `CD_DOT_DATE : `CD_DOT_TIME;
    for (int i = 0; i < `CD_DIGITS; i++) begin
      next_bank[i].blink = blink_mask[i];
      next_bank[i].dot   = dot_mask[i];
      next_bank[i].code  = is_date ? date_codes[i] : time_codes[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      leds <= '0;
    end else if (decoded) begin
      leds <= next_bank;
    end
  end

endmodule

// File: verilog/time_editor.sv
`include "clock_display_defines.svh"

module time_editor (
  input  logic                         clk,
  input  logic                         rst_n,
  input  clock_display_pkg::mode_e     mode,
  input  clock_display_pkg::bcd_time_t live_time,
  input  logic                         btn_down,
  output clock_display_pkg::bcd_time_t edit_time,
  output logic                         set_counter,
  output clock_display_pkg::bcd_time_t set_time
);

  clock_display_pkg::mode_e prev_mode;

  logic [15:0] year_next;
  logic [7:0]  month_next;
  logic [7:0]  day_next;
  logic [7:0]  hour_next;
  logic [7:0]  minute_next;
  logic [7:0]  second_next;
  logic        prev_was_edit;
  logic        commit;

  bcd_field_incr #(.field_t(logic [7:0]), .MAX(`CD_SEC_MAX)) u_second_incr (
    .value      (edit_time.second),
    .next_value (second_next)
  );

  bcd_field_incr #(.field_t(logic [7:0]), .MAX(`CD_MIN_MAX)) u_minute_incr (
    .value      (edit_time.minute),
    .next_value (minute_next)
  );

  bcd_field_incr #(.field_t(logic [7:0]), .MAX(`CD_HOUR_MAX)) u_hour_incr (
    .value      (edit_time.hour),
    .next_value (hour_next)
  );

  bcd_field_incr #(.field_t(logic [7:0]), .MAX(`CD_DAY_MAX)) u_day_incr (
    .value      (edit_time.day),
    .next_value (day_next)
  );

  bcd_field_incr #(.field_t(logic [7:0]), .MAX(`CD_MONTH_MAX)) u_month_incr (
    .value      (edit_time.month),
    .next_value (month_next)
  );

  bcd_field_incr #(.field_t(logic [15:0]), .MAX(`CD_YEAR_MAX)) u_year_incr (
    .value      (edit_time.year),
    .next_value (year_next)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edit_time <= '0;
    end else begin
      case (mode)
        clock_display_pkg::time_disp,
        clock_display_pkg::date_disp:   edit_time <= live_time;  // track live time
        clock_display_pkg::edit_second: if (!btn_down) edit_time.second <= second_next;
        clock_display_pkg::edit_minute: if (!btn_down) edit_time.minute <= minute_next;
        clock_display_pkg::edit_hour:   if (!btn_down) edit_time.hour <= hour_next;
        clock_display_pkg::edit_day:    if (!btn_down) edit_time.day <= day_next;
        clock_display_pkg::edit_month:  if (!btn_down) edit_time.month <= month_next;
        clock_display_pkg::edit_year:   if (!btn_down) edit_time.year <= year_next;
        default: ;
      endcase
    end
  end

  assign prev_was_edit = prev_mode inside {[clock_display_pkg::edit_second :
                                             clock_display_pkg::edit_year]};
  assign commit = prev_was_edit && (mode == clock_display_pkg::time_disp);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_mode   <= clock_display_pkg::time_disp;
      set_counter <= 1'b0;
      set_time    <= '0;
    end else begin
      prev_mode   <= mode;
      set_counter <= commit;  // single cycle
      if (commit) begin
        set_time <= edit_time;  // value before this edge
      end
    end
  end

endmodule
